// ==== design/mac_mem_pkg.sv ====
// Memory map and data widths shared by the download path and the SDRAM mux.
// SDRAM is word addressed; chipset and loader addresses count bytes.

package mac_mem_pkg;

	// ========================================================================
	// Bus widths
	// ========================================================================
	localparam int SDRAM_AW = 25;
	localparam int DATA_W   = 16;
	localparam int MEM_AW   = 22;
	localparam int IOCTL_AW = 25;

	// Download offset is 2 target bits above 19 word bits
	localparam int DIO_AW = 21;

	// ========================================================================
	// SDRAM map
	// ========================================================================
	// Downloads land above the OS ROM region
	localparam logic [3:0] DIO_REGION_PREFIX = 4'b0001;

	// Set for ROM reads, RAM lives below it
	localparam int ROM_SELECT_BIT = 21;

	// ========================================================================
	// Floppy images, final loader word address
	// ========================================================================
	// 819200 byte image
	localparam logic [IOCTL_AW-2:0] DSK_WORDS_DS = (IOCTL_AW-1)'(409600);
	// 409600 byte image
	localparam logic [IOCTL_AW-2:0] DSK_WORDS_SS = (IOCTL_AW-1)'(204800);

	// Black screen while the loader owns the bus
	localparam logic [DATA_W-1:0] DOWNLOAD_FILL = '1;

endpackage

// ==== design/mac_ctrl_pkg.sv ====
// Control encodings and timing constants for the system glue.
// Hold counts are short so simulation stays fast; real hardware wants more.

package mac_ctrl_pkg;

	typedef enum logic [1:0] {
		CPU_68000 = 2'd0,
		CPU_68010 = 2'd1,
		CPU_68020 = 2'd2
	} cpu_model_e;

	typedef enum logic {
		MEM_1MB = 1'b0,
		MEM_4MB = 1'b1
	} mem_size_e;

	// Loader index, low two bits also pick the SDRAM region
	typedef enum logic [7:0] {
		DIO_ROM        = 8'd0,
		DIO_FLOPPY_INT = 8'd1,
		DIO_FLOPPY_EXT = 8'd2
	} dio_target_e;

	localparam int RESET_HOLD_TICKS = 32;
	localparam int RESET_CNT_W      = $clog2(RESET_HOLD_TICKS + 1);
	localparam int ACT_HOLD_CYCLES  = 200;
	localparam int ACT_CNT_W        = 8;
	localparam int NUM_DRIVES       = 2;

endpackage

// ==== design/reset_sequencer.sv ====
// Runs only on clk8_en_p ticks; without ticks the reset state is frozen.
// A setting change is seen one tick after it happens.

module reset_sequencer (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     clk8_en_p,
	input  logic                     pll_locked,
	input  logic                     ext_reset,
	input  logic                     user_button,
	input  logic                     status_reset,
	input  logic                     cpu_reset_req_n,
	input  mac_ctrl_pkg::mem_size_e  mem_config,
	input  mac_ctrl_pkg::cpu_model_e cpu_config,
	output logic                     sys_reset_n
);
	import mac_ctrl_pkg::*;

	mem_size_e              last_mem;
	cpu_model_e             last_cpu;
	logic [RESET_CNT_W-1:0] hold_cnt;
	logic                   reset_src;

	// Any of these restarts the hold
	assign reset_src = !pll_locked || ext_reset || user_button || status_reset ||
		(mem_config != last_mem) || (cpu_config != last_cpu) || !cpu_reset_req_n;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			last_mem    <= MEM_1MB;
			last_cpu    <= CPU_68000;
			hold_cnt    <= RESET_CNT_W'(RESET_HOLD_TICKS);
			sys_reset_n <= 1'b0;
		end else if (clk8_en_p) begin
			last_mem <= mem_config;
			last_cpu <= cpu_config;
			if (reset_src) begin
				hold_cnt    <= RESET_CNT_W'(RESET_HOLD_TICKS);
				sys_reset_n <= 1'b0;
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - RESET_CNT_W'(1);
			end else begin
				// Count ran out on an earlier tick
				sys_reset_n <= 1'b1;
			end
		end
	end

endmodule

// ==== design/floppy_image_detect.sv ====
// One instance per drive; only sizes of exactly 400K or 800K are accepted.
// Flags are valid one cycle after dio_download falls.

module floppy_image_detect #(
	parameter mac_ctrl_pkg::dio_target_e DRIVE_TARGET = mac_ctrl_pkg::DIO_FLOPPY_INT
) (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  logic                            dio_download,
	input  logic                            eject,
	input  mac_ctrl_pkg::dio_target_e       dio_index,
	input  logic [mac_mem_pkg::IOCTL_AW-2:0] dio_words,
	output logic                            disk_ins,
	output logic                            disk_ds
);
	import mac_mem_pkg::*;

	logic download_q;
	logic disk_ss;
	logic download_end;

	assign download_end = download_q && !dio_download && (dio_index == DRIVE_TARGET);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			download_q <= 1'b0;
			disk_ds    <= 1'b0;
			disk_ss    <= 1'b0;
		end else begin
			download_q <= dio_download;
			// Eject from the OS wins over a finishing download
			if (eject) begin
				disk_ds <= 1'b0;
				disk_ss <= 1'b0;
			end else if (download_end) begin
				disk_ds <= (dio_words == DSK_WORDS_DS);
				disk_ss <= (dio_words == DSK_WORDS_SS);
			end
		end
	end

	// Unknown sizes leave the drive empty
	assign disk_ins = disk_ds | disk_ss;

endmodule

// ==== design/download_buffer.sv ====
// Holds a single loader word; the loader must not strobe while ioctl_wait is high.
// A word is written in the first complete download slot after the strobe.

module download_buffer (
	input  logic                             clk_sys,
	input  logic                             rst_n,
	input  logic                             ioctl_wr,
	input  logic                             dio_bus_control,
	input  logic [mac_mem_pkg::IOCTL_AW-1:0] ioctl_addr,
	input  logic [mac_mem_pkg::DATA_W-1:0]   ioctl_data,
	input  mac_ctrl_pkg::dio_target_e        dio_index,
	output logic                             ioctl_wait,
	output logic                             dio_write,
	output logic [mac_mem_pkg::DIO_AW-1:0]   dio_a,
	output logic [mac_mem_pkg::DATA_W-1:0]   dio_data
);
	import mac_mem_pkg::*;

	logic bus_control_q;

	// Payload, loaded on every strobe
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dio_data <= '0;
			dio_a    <= '0;
		end else if (ioctl_wr) begin
			// Loader sends little endian, the 68k bus is big endian
			dio_data <= {ioctl_data[DATA_W/2-1:0], ioctl_data[DATA_W-1:DATA_W/2]};
			dio_a    <= {dio_index[1:0], ioctl_addr[19:1]};
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ioctl_wait    <= 1'b0;
			dio_write     <= 1'b0;
			bus_control_q <= 1'b0;
		end else begin
			bus_control_q <= dio_bus_control;
			if (ioctl_wr)
				ioctl_wait <= 1'b1;
			// Arm the write only between slots so a slot is never cut short
			if (!dio_bus_control)
				dio_write <= ioctl_wait;
			// Slot just ended with the write armed
			if (bus_control_q && !dio_bus_control && dio_write)
				ioctl_wait <= 1'b0;
		end
	end

endmodule

// ==== design/sdram_port_mux.sv ====
// Purely combinational; the loader owns SDRAM only while downloading in its slot.
// Disk reads are byte wide and are spread over both halves of the word.

module sdram_port_mux (
	input  logic                                 dio_download,
	input  logic                                 dio_bus_control,
	input  logic                                 dio_write,
	input  logic [mac_mem_pkg::DIO_AW-1:0]       dio_a,
	input  logic [mac_mem_pkg::DATA_W-1:0]       dio_data,
	input  logic [mac_mem_pkg::MEM_AW-1:0]       mem_addr,
	input  logic [mac_mem_pkg::DATA_W-1:0]       mem_dout,
	input  logic                                 rom_oe_n,
	input  logic                                 ram_oe_n,
	input  logic                                 ram_we_n,
	input  logic                                 mem_uds_n,
	input  logic                                 mem_lds_n,
	input  logic [mac_ctrl_pkg::NUM_DRIVES-1:0]  dsk_read_ack,
	input  logic [mac_mem_pkg::DATA_W-1:0]       sdram_out,
	output logic [mac_mem_pkg::SDRAM_AW-1:0]     sdram_addr,
	output logic [mac_mem_pkg::DATA_W-1:0]       sdram_din,
	output logic [1:0]                           sdram_ds,
	output logic                                 sdram_we,
	output logic                                 sdram_oe,
	output logic [mac_mem_pkg::DATA_W-1:0]       sdram_do
);
	import mac_mem_pkg::*;

	logic                download_cycle;
	logic [SDRAM_AW-1:0] mem_sdram_addr;
	logic [DATA_W-1:0]   disk_byte;

	assign download_cycle = dio_download && dio_bus_control;

	// ROM and RAM map straight onto SDRAM words
	always_comb begin
		mem_sdram_addr                       = '0;
		mem_sdram_addr[ROM_SELECT_BIT]       = !rom_oe_n;
		mem_sdram_addr[ROM_SELECT_BIT-1:0]   = mem_addr[MEM_AW-1:1];
	end

	// Odd byte address takes the low half
	assign disk_byte = mem_addr[0] ? {2{sdram_out[DATA_W/2-1:0]}}
	                               : {2{sdram_out[DATA_W-1:DATA_W/2]}};

	assign sdram_addr = download_cycle ? {DIO_REGION_PREFIX, dio_a} : mem_sdram_addr;
	assign sdram_din  = download_cycle ? dio_data : mem_dout;
	assign sdram_ds   = download_cycle ? 2'b11 : {!mem_uds_n, !mem_lds_n};
	assign sdram_we   = download_cycle ? dio_write : !ram_we_n;
	assign sdram_oe   = download_cycle ? 1'b0 : (!ram_oe_n || !rom_oe_n);
	assign sdram_do   = download_cycle ? DOWNLOAD_FILL :
	                    (|dsk_read_ack) ? disk_byte : sdram_out;

endmodule

// ==== design/disk_activity_led.sv ====
// Activity is stretched to ACT_HOLD_CYCLES clocks, the pulse lags one cycle.
// With a motor running the LED is lit and activity blinks it off.

module disk_activity_led (
	input  logic                                clk_sys,
	input  logic                                rst_n,
	input  logic                                dio_download,
	input  logic [mac_ctrl_pkg::NUM_DRIVES-1:0] disk_act,
	input  logic [mac_ctrl_pkg::NUM_DRIVES-1:0] disk_motor,
	output logic                                led_user
);
	import mac_ctrl_pkg::*;

	logic [ACT_CNT_W-1:0] hold_cnt;
	logic                 act_pulse;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			hold_cnt  <= '0;
			act_pulse <= 1'b0;
		end else begin
			act_pulse <= (hold_cnt != '0);
			if (|disk_act)
				hold_cnt <= ACT_CNT_W'(ACT_HOLD_CYCLES);
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - ACT_CNT_W'(1);
		end
	end

	assign led_user = dio_download || (act_pulse ^ (|disk_motor));

endmodule

// ==== design/mac_glue_top.sv ====
// Glue around CPU, chipset and SDRAM controller, which live outside this top.
// clk8_en_p and dio_bus_control come from the bus timing controller.

module mac_glue_top (
	input  logic                                 clk_sys,
	input  logic                                 rst_n,
	input  logic                                 clk8_en_p,
	input  logic                                 pll_locked,
	input  logic                                 ext_reset,
	input  logic                                 user_button,
	input  logic                                 status_reset,
	input  mac_ctrl_pkg::mem_size_e              mem_config,
	input  mac_ctrl_pkg::cpu_model_e             cpu_config,
	input  logic                                 cpu_reset_req_n,
	input  logic                                 dio_download,
	input  mac_ctrl_pkg::dio_target_e            dio_index,
	input  logic                                 ioctl_wr,
	input  logic [mac_mem_pkg::IOCTL_AW-1:0]     ioctl_addr,
	input  logic [mac_mem_pkg::DATA_W-1:0]       ioctl_data,
	input  logic                                 dio_bus_control,
	input  logic [mac_ctrl_pkg::NUM_DRIVES-1:0]  disk_eject,
	input  logic [mac_ctrl_pkg::NUM_DRIVES-1:0]  disk_motor,
	input  logic [mac_ctrl_pkg::NUM_DRIVES-1:0]  disk_act,
	input  logic [mac_mem_pkg::MEM_AW-1:0]       mem_addr,
	input  logic                                 rom_oe_n,
	input  logic                                 ram_oe_n,
	input  logic                                 ram_we_n,
	input  logic                                 mem_uds_n,
	input  logic                                 mem_lds_n,
	input  logic [mac_mem_pkg::DATA_W-1:0]       mem_dout,
	input  logic [mac_ctrl_pkg::NUM_DRIVES-1:0]  dsk_read_ack,
	input  logic [mac_mem_pkg::DATA_W-1:0]       sdram_out,
	output logic                                 sys_reset_n,
	output logic [mac_ctrl_pkg::NUM_DRIVES-1:0]  disk_ins,
	output logic [mac_ctrl_pkg::NUM_DRIVES-1:0]  disk_ds,
	output logic                                 ioctl_wait,
	output logic [mac_mem_pkg::SDRAM_AW-1:0]     sdram_addr,
	output logic [mac_mem_pkg::DATA_W-1:0]       sdram_din,
	output logic [1:0]                           sdram_ds,
	output logic                                 sdram_we,
	output logic                                 sdram_oe,
	output logic [mac_mem_pkg::DATA_W-1:0]       sdram_do,
	output logic                                 led_user
);
	import mac_mem_pkg::*;
	import mac_ctrl_pkg::*;

	logic              dio_write;
	logic [DIO_AW-1:0] dio_a;
	logic [DATA_W-1:0] dio_data;

	// ========================================================================
	// Reset and floppy status
	// ========================================================================
	reset_sequencer i_reset_sequencer (
		.clk_sys, .rst_n, .clk8_en_p, .pll_locked, .ext_reset, .user_button,
		.status_reset, .cpu_reset_req_n, .mem_config, .cpu_config, .sys_reset_n
	);

	// Loader address counts bytes, image size is checked in words
	floppy_image_detect #(.DRIVE_TARGET(DIO_FLOPPY_INT)) i_floppy_int (
		.clk_sys, .rst_n, .dio_download, .eject(disk_eject[0]), .dio_index,
		.dio_words(ioctl_addr[IOCTL_AW-1:1]), .disk_ins(disk_ins[0]), .disk_ds(disk_ds[0])
	);

	floppy_image_detect #(.DRIVE_TARGET(DIO_FLOPPY_EXT)) i_floppy_ext (
		.clk_sys, .rst_n, .dio_download, .eject(disk_eject[1]), .dio_index,
		.dio_words(ioctl_addr[IOCTL_AW-1:1]), .disk_ins(disk_ins[1]), .disk_ds(disk_ds[1])
	);

	// ========================================================================
	// Download and SDRAM port
	// ========================================================================
	download_buffer i_download_buffer (
		.clk_sys, .rst_n, .ioctl_wr, .dio_bus_control, .ioctl_addr, .ioctl_data,
		.dio_index, .ioctl_wait, .dio_write, .dio_a, .dio_data
	);

	sdram_port_mux i_sdram_port_mux (
		.dio_download, .dio_bus_control, .dio_write, .dio_a, .dio_data,
		.mem_addr, .mem_dout, .rom_oe_n, .ram_oe_n, .ram_we_n, .mem_uds_n, .mem_lds_n,
		.dsk_read_ack, .sdram_out, .sdram_addr, .sdram_din, .sdram_ds, .sdram_we,
		.sdram_oe, .sdram_do
	);

	disk_activity_led i_disk_activity_led (
		.clk_sys, .rst_n, .dio_download, .disk_act, .disk_motor, .led_user
	);

endmodule

// ==== test/tb_clock_gen.sv ====
// Free running clk_sys with a period of 10 time units.
// rst_n is held low for the first 3 clock cycles.

module tb_clock_gen (
	output logic clk_sys,
	output logic rst_n
);

	localparam int HALF_PERIOD = 5;

	initial begin
		clk_sys = 1'b0;
		forever #HALF_PERIOD clk_sys = ~clk_sys;
	end

	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
	end

endmodule

// ==== test/tb_mac_glue.sv ====
// Random stimulus from a fixed LFSR seed, checked against models of the glue rules.
// Inputs change on the falling edge; outputs are sampled in the low phase.

module tb_mac_glue;
	import mac_mem_pkg::*;
	import mac_ctrl_pkg::*;

	localparam int RESET_TRIALS  = 8;
	localparam int FLOPPY_TRIALS = 24;
	localparam int DL_TRIALS     = 24;
	localparam int MEM_TRIALS    = 200;
	localparam int LED_CYCLES    = 1500;
	// Worst case cycles of each test plus a margin
	localparam int MAX_CYCLES = RESET_TRIALS * (RESET_HOLD_TICKS + 3) * 4 +
		FLOPPY_TRIALS * 8 + DL_TRIALS * 14 + MEM_TRIALS + LED_CYCLES + 500;

	logic                  clk_sys;
	logic                  rst_n;
	logic                  clk8_en_p = 1'b0;
	logic                  pll_locked;
	logic                  ext_reset;
	logic                  user_button;
	logic                  status_reset;
	mem_size_e             mem_config;
	cpu_model_e            cpu_config;
	logic                  cpu_reset_req_n;
	logic                  dio_download;
	dio_target_e           dio_index;
	logic                  ioctl_wr;
	logic [IOCTL_AW-1:0]   ioctl_addr;
	logic [DATA_W-1:0]     ioctl_data;
	logic                  dio_bus_control;
	logic [NUM_DRIVES-1:0] disk_eject;
	logic [NUM_DRIVES-1:0] disk_motor;
	logic [NUM_DRIVES-1:0] disk_act;
	logic [MEM_AW-1:0]     mem_addr;
	logic                  rom_oe_n;
	logic                  ram_oe_n;
	logic                  ram_we_n;
	logic                  mem_uds_n;
	logic                  mem_lds_n;
	logic [DATA_W-1:0]     mem_dout;
	logic [NUM_DRIVES-1:0] dsk_read_ack;
	logic [DATA_W-1:0]     sdram_out;
	logic                  sys_reset_n;
	logic [NUM_DRIVES-1:0] disk_ins;
	logic [NUM_DRIVES-1:0] disk_ds;
	logic                  ioctl_wait;
	logic [SDRAM_AW-1:0]   sdram_addr;
	logic [DATA_W-1:0]     sdram_din;
	logic [1:0]            sdram_ds;
	logic                  sdram_we;
	logic                  sdram_oe;
	logic [DATA_W-1:0]     sdram_do;
	logic                  led_user;

	logic [31:0]           lfsr = 32'h3849;
	logic [1:0]            en_cnt = 2'd0;
	int                    errors = 0;
	int                    cycles = 0;
	logic [NUM_DRIVES-1:0] exp_ins = '0;
	logic [NUM_DRIVES-1:0] exp_ds = '0;

	tb_clock_gen i_clock_gen (.clk_sys, .rst_n);

	mac_glue_top i_dut (.*);

	// Galois LFSR, one step for each bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int          i;
		r = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic wait_tick();
		do @(posedge clk_sys); while (!clk8_en_p);
	endtask

	// 8 MHz enable, one cycle in four
	always @(negedge clk_sys) begin
		clk8_en_p = (en_cnt == 2'd3);
		en_cnt = en_cnt + 2'd1;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not complete", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ========================================================================
	// Tests
	// ========================================================================
	task automatic reset_trial();
		logic [31:0] r;
		int          src;
		int          n;
		r = rand_bits(4);
		src = int'(r[2:0]) % 6;
		case (src)
			0: pll_locked = 1'b0;
			1: ext_reset = 1'b1;
			2: user_button = 1'b1;
			3: status_reset = 1'b1;
			4: cpu_reset_req_n = 1'b0;
			default: begin
				if (r[3])
					mem_config = (mem_config == MEM_1MB) ? MEM_4MB : MEM_1MB;
				else
					cpu_config = cpu_model_e'(2'((int'(cpu_config) + 1) % 3));
			end
		endcase
		wait_tick();
		@(negedge clk_sys);
		check_value("reset_assert", 32'd0, 32'(sys_reset_n));
		pll_locked = 1'b1;
		ext_reset = 1'b0;
		user_button = 1'b0;
		status_reset = 1'b0;
		cpu_reset_req_n = 1'b1;
		for (n = 1; n <= RESET_HOLD_TICKS + 1; n++) begin
			wait_tick();
			@(negedge clk_sys);
			check_value("reset_release", 32'(n == RESET_HOLD_TICKS + 1), 32'(sys_reset_n));
		end
	endtask

	task automatic floppy_trial();
		logic [31:0]         r;
		logic [IOCTL_AW-2:0] words;
		int                  tgt;
		int                  d;
		tgt = int'(rand_bits(2) % 3);
		r = rand_bits(25);
		case (int'(rand_bits(2) % 3))
			0: ioctl_addr = {DSK_WORDS_DS, 1'b0};
			1: ioctl_addr = {DSK_WORDS_SS, 1'b0};
			default: ioctl_addr = r[IOCTL_AW-1:0];
		endcase
		dio_index = dio_target_e'(8'(tgt));
		dio_download = 1'b1;
		repeat (1 + int'(rand_bits(2))) @(negedge clk_sys);
		dio_download = 1'b0;
		@(negedge clk_sys);
		words = ioctl_addr[IOCTL_AW-1:1];
		for (d = 0; d < NUM_DRIVES; d++) begin
			if (tgt == d + 1) begin
				exp_ds[d] = (words == DSK_WORDS_DS);
				exp_ins[d] = exp_ds[d] || (words == DSK_WORDS_SS);
			end
		end
		check_value("floppy_ins", 32'(exp_ins), 32'(disk_ins));
		check_value("floppy_ds", 32'(exp_ds), 32'(disk_ds));
		r = rand_bits(2);
		if (r[0]) begin
			d = int'(r[1]);
			disk_eject[d] = 1'b1;
			exp_ins[d] = 1'b0;
			exp_ds[d] = 1'b0;
			@(negedge clk_sys);
			disk_eject = '0;
			check_value("eject_ins", 32'(exp_ins), 32'(disk_ins));
			check_value("eject_ds", 32'(exp_ds), 32'(disk_ds));
		end
	endtask

	task automatic download_trial();
		logic [31:0]         a;
		logic [31:0]         dt;
		logic [SDRAM_AW-1:0] exp_addr;
		int                  tgt;
		tgt = int'(rand_bits(2) % 3);
		a = rand_bits(25);
		dt = rand_bits(16);
		dio_index = dio_target_e'(8'(tgt));
		ioctl_addr = a[IOCTL_AW-1:0];
		ioctl_data = dt[DATA_W-1:0];
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		check_value("dl_wait_set", 32'd1, 32'(ioctl_wait));
		repeat (1 + int'(rand_bits(2))) @(negedge clk_sys);
		dio_bus_control = 1'b1;
		exp_addr = {DIO_REGION_PREFIX, 2'(tgt), a[19:1]};
		repeat (1 + int'(rand_bits(2))) begin
			#2;
			check_value("dl_addr", 32'(exp_addr), 32'(sdram_addr));
			check_value("dl_din", 32'({dt[7:0], dt[15:8]}), 32'(sdram_din));
			check_value("dl_ds", 32'd3, 32'(sdram_ds));
			check_value("dl_we", 32'd1, 32'(sdram_we));
			check_value("dl_oe", 32'd0, 32'(sdram_oe));
			check_value("dl_do", 32'hffff, 32'(sdram_do));
			@(negedge clk_sys);
		end
		check_value("dl_wait_slot", 32'd1, 32'(ioctl_wait));
		dio_bus_control = 1'b0;
		@(negedge clk_sys);
		check_value("dl_wait_clear", 32'd0, 32'(ioctl_wait));
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic mem_trial();
		logic [31:0]         r;
		logic [31:0]         a;
		logic [31:0]         w;
		logic [31:0]         o;
		logic [SDRAM_AW-1:0] exp_addr;
		logic [DATA_W-1:0]   exp_do;
		a = rand_bits(22);
		r = rand_bits(8);
		w = rand_bits(16);
		o = rand_bits(16);
		mem_addr = a[MEM_AW-1:0];
		rom_oe_n = r[0];
		ram_oe_n = r[1];
		ram_we_n = r[2];
		mem_uds_n = r[3];
		mem_lds_n = r[4];
		dsk_read_ack = r[5] ? r[7:6] : 2'b00;
		mem_dout = w[DATA_W-1:0];
		sdram_out = o[DATA_W-1:0];
		#2;
		exp_addr = {3'b000, !r[0], a[21:1]};
		if (dsk_read_ack == 2'b00)
			exp_do = o[15:0];
		else if (a[0])
			exp_do = {o[7:0], o[7:0]};
		else
			exp_do = {o[15:8], o[15:8]};
		check_value("mem_addr", 32'(exp_addr), 32'(sdram_addr));
		check_value("mem_din", w & 32'hffff, 32'(sdram_din));
		check_value("mem_ds", 32'({!r[3], !r[4]}), 32'(sdram_ds));
		check_value("mem_we", 32'(!r[2]), 32'(sdram_we));
		check_value("mem_oe", 32'(!r[1] || !r[0]), 32'(sdram_oe));
		check_value("mem_do", 32'(exp_do), 32'(sdram_do));
		@(negedge clk_sys);
	endtask

	task automatic led_run();
		logic [31:0] r;
		int          cnt;
		int          pulse;
		int          i;
		cnt = 0;
		pulse = 0;
		for (i = 0; i < LED_CYCLES; i++) begin
			r = rand_bits(16);
			// Rare activity so the hold runs out between bursts
			disk_act = (r[6:0] == 7'd0) ? r[8:7] : 2'b00;
			if (r[11:9] == 3'd0)
				disk_motor = r[13:12];
			if (r[15:14] == 2'b11)
				dio_download = !dio_download;
			#2;
			check_value("led_user", 32'(dio_download || ((pulse != 0) ^ (|disk_motor))),
				32'(led_user));
			@(posedge clk_sys);
			pulse = (cnt != 0) ? 1 : 0;
			if (|disk_act)
				cnt = ACT_HOLD_CYCLES;
			else if (cnt != 0)
				cnt--;
			@(negedge clk_sys);
		end
		disk_act = '0;
	endtask

	initial begin
		pll_locked = 1'b1;
		ext_reset = 1'b0;
		user_button = 1'b0;
		status_reset = 1'b0;
		mem_config = MEM_1MB;
		cpu_config = CPU_68000;
		cpu_reset_req_n = 1'b1;
		dio_download = 1'b0;
		dio_index = DIO_ROM;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_data = '0;
		dio_bus_control = 1'b0;
		disk_eject = '0;
		disk_motor = '0;
		disk_act = '0;
		mem_addr = '0;
		rom_oe_n = 1'b1;
		ram_oe_n = 1'b1;
		ram_we_n = 1'b1;
		mem_uds_n = 1'b1;
		mem_lds_n = 1'b1;
		mem_dout = '0;
		dsk_read_ack = '0;
		sdram_out = '0;
		@(posedge rst_n);
		@(negedge clk_sys);
		repeat (RESET_TRIALS) reset_trial();
		repeat (FLOPPY_TRIALS) floppy_trial();
		// Download stays up over all words, ends on ROM so no drive latches
		dio_download = 1'b1;
		// Chipset keeps a RAM read pending that the slot has to override
		ram_oe_n = 1'b0;
		@(negedge clk_sys);
		repeat (DL_TRIALS) download_trial();
		dio_index = DIO_ROM;
		dio_download = 1'b0;
		@(negedge clk_sys);
		repeat (MEM_TRIALS) mem_trial();
		led_run();
		$display("Checks complete, errors: %0d", errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== tb.f ====
design/mac_mem_pkg.sv
design/mac_ctrl_pkg.sv
design/reset_sequencer.sv
design/floppy_image_detect.sv
design/download_buffer.sv
design/sdram_port_mux.sv
design/disk_activity_led.sv
design/mac_glue_top.sv
test/tb_clock_gen.sv
test/tb_mac_glue.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build with Verilator, run, and judge the result from the simulation log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_mac_glue -o tb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "Simulation FAILED" sim.log \
	&& { echo "Test failed, see sim.log"; exit 1; } \
	|| { echo "Test passed"; exit 0; }
